// File: Makefile
VERILATOR ?= verilator
TOP       := tb_dma_app
FILELIST  := dma_app.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dma_app.f
rtl/dma_pkg.sv
rtl/dma_wr_engine.sv
rtl/dma_rd_engine.sv
rtl/app_port_arbiter.sv
rtl/dma_app_top.sv
testbench/app_mem_model.sv
testbench/tb_dma_app.sv

// File: rtl/app_port_arbiter.sv
`timescale 1ns/100ps

module app_port_arbiter (
    input  logic              ui_clk,
    input  logic              arst_n,
    input  logic              rd_req,     // channel 0
    input  logic              wr_req,     // channel 1
    input  logic              rd_done,
    input  logic              wr_done,
    input  dma_pkg::app_req_t rd_app,
    input  dma_pkg::app_req_t wr_app,
    output logic              rd_start,
    output logic              wr_start,
    output dma_pkg::app_req_t app
);

    typedef enum logic [1:0] {
        IDLE,
        OWN_RD,
        OWN_WR
    } state_e;

    state_e state;
    logic   last_wr;    // last burst went to the write channel
    logic   pick_rd;

    // read wins unless write is waiting and read went last
    assign pick_rd = rd_req && (!wr_req || last_wr);

    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            last_wr  <= 1'b1;    // so read goes first
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (pick_rd) begin
                        state    <= OWN_RD;
                        rd_start <= 1'b1;
                        last_wr  <= 1'b0;
                    end else if (wr_req) begin
                        state    <= OWN_WR;
                        wr_start <= 1'b1;
                        last_wr  <= 1'b1;
                    end
                end
                OWN_RD: begin
                    if (rd_done) begin
                        state <= IDLE;
                    end
                end
                OWN_WR: begin
                    if (wr_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // only the owner reaches the port
    always_comb begin
        case (state)
            OWN_RD:  app = rd_app;
            OWN_WR:  app = wr_app;
            default: app = '0;
        endcase
    end

    a_one_grant : assert property (
        @(posedge ui_clk) disable iff (!arst_n)
        !(rd_start && wr_start)
    ) else $error("both channels granted");

    // engines must never be active at the same time
    a_one_active : assert property (
        @(posedge ui_clk) disable iff (!arst_n)
        !(rd_app.en && wr_app.en)
    ) else $error("read and write engines both driving app");

endmodule

// File: rtl/dma_app_top.sv
`timescale 1ns/100ps

module dma_app_top #(
    parameter int DATA_W = 256
) (
    input  logic                ui_clk,
    input  logic                arst_n,
    // write channel source
    input  logic                wr_req,
    input  dma_pkg::burst_cmd_t wr_cmd,
    input  logic [DATA_W-1:0]   wr_data,
    output logic                wr_data_pop,
    output logic                wr_done,
    // read channel sink
    input  logic                rd_req,
    input  dma_pkg::burst_cmd_t rd_cmd,
    output logic [DATA_W-1:0]   rd_data,
    output logic                rd_data_valid,
    output logic                rd_done,
    // controller app port
    output dma_pkg::app_req_t   app,
    output logic [DATA_W-1:0]   app_wdf_data,
    output logic                app_wdf_wren,
    output logic                app_wdf_end,
    input  logic                app_rdy,
    input  logic                app_wdf_rdy,
    input  logic [DATA_W-1:0]   app_rd_data,
    input  logic                app_rd_data_valid
);
    import dma_pkg::*;

    logic     wr_start;
    logic     rd_start;
    app_req_t wr_app;
    app_req_t rd_app;

    dma_wr_engine #(
        .DATA_W ( DATA_W )
    ) i_wr (
        .ui_clk      ( ui_clk       ),
        .arst_n      ( arst_n       ),
        .start       ( wr_start     ),
        .cmd         ( wr_cmd       ),
        .src_data    ( wr_data      ),
        .app_rdy     ( app_rdy      ),
        .app_wdf_rdy ( app_wdf_rdy  ),
        .app         ( wr_app       ),
        .wdf_data    ( app_wdf_data ),
        .wdf_wren    ( app_wdf_wren ),
        .wdf_end     ( app_wdf_end  ),
        .src_pop     ( wr_data_pop  ),
        .done        ( wr_done      )
    );

    dma_rd_engine #(
        .DATA_W ( DATA_W )
    ) i_rd (
        .ui_clk            ( ui_clk            ),
        .arst_n            ( arst_n            ),
        .start             ( rd_start          ),
        .cmd               ( rd_cmd            ),
        .app_rdy           ( app_rdy           ),
        .app_rd_data       ( app_rd_data       ),
        .app_rd_data_valid ( app_rd_data_valid ),
        .app               ( rd_app            ),
        .rd_data           ( rd_data           ),
        .rd_data_valid     ( rd_data_valid     ),
        .done              ( rd_done           )
    );

    // read is channel 0
    app_port_arbiter i_arb (
        .ui_clk   ( ui_clk   ),
        .arst_n   ( arst_n   ),
        .rd_req   ( rd_req   ),
        .wr_req   ( wr_req   ),
        .rd_done  ( rd_done  ),
        .wr_done  ( wr_done  ),
        .rd_app   ( rd_app   ),
        .wr_app   ( wr_app   ),
        .rd_start ( rd_start ),
        .wr_start ( wr_start ),
        .app      ( app      )
    );

endmodule

// File: rtl/dma_pkg.sv
package dma_pkg;

    // app port address in one constant word
    localparam int ADDR_W = 28;

    // burst length in beats
    localparam int LEN_W = 8;

    // one 256-bit beat spans eight 32-bit columns
    localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(8);

    // controller opcode encoding
    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } app_cmd_e;

    // one burst request from a channel source
    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // first beat address
        logic [LEN_W-1:0]  len;    // beat count that is never zero
    } burst_cmd_t;

    // one command on the controller app port
    typedef struct packed {
        logic              en;
        app_cmd_e          cmd;
        logic [ADDR_W-1:0] addr;
    } app_req_t;

endpackage

// File: rtl/dma_rd_engine.sv
`timescale 1ns/100ps

module dma_rd_engine #(
    parameter int DATA_W = 256
) (
    input  logic                ui_clk,
    input  logic                arst_n,
    input  logic                start,              // grant pulse from arbiter
    input  dma_pkg::burst_cmd_t cmd,
    input  logic                app_rdy,
    input  logic [DATA_W-1:0]   app_rd_data,
    input  logic                app_rd_data_valid,
    output dma_pkg::app_req_t   app,
    output logic [DATA_W-1:0]   rd_data,
    output logic                rd_data_valid,
    output logic                done
);
    import dma_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } state_e;

    state_e            state;
    logic [ADDR_W-1:0] issue_addr;
    logic [LEN_W-1:0]  issue_left;   // commands still to send
    logic [LEN_W-1:0]  rcv_cnt;      // beats already returned
    logic [LEN_W-1:0]  len_q;
    logic              cmd_xfer;
    logic              last_data;

    assign cmd_xfer  = (state == ISSUE) && app_rdy;
    // returned count against the command count of the burst
    assign last_data = app_rd_data_valid && (rcv_cnt == len_q - 1'b1);

    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            issue_left <= '0;
            rcv_cnt    <= '0;
            len_q      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= ISSUE;
                        issue_left <= cmd.len;
                        len_q      <= cmd.len;
                        rcv_cnt    <= '0;
                    end
                end
                ISSUE: begin
                    if (cmd_xfer) begin
                        issue_left <= issue_left - 1'b1;
                        if (issue_left == LEN_W'(1)) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (last_data) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            // data may return while commands are still going out
            if (state != IDLE && app_rd_data_valid) begin
                rcv_cnt <= rcv_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (state == IDLE && start) begin
            issue_addr <= cmd.addr;
        end else if (cmd_xfer) begin
            issue_addr <= issue_addr + ADDR_STEP;
        end
    end

    // returned beats delayed by one cycle
    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data_valid <= 1'b0;
            done          <= 1'b0;
        end else begin
            rd_data_valid <= app_rd_data_valid;
            done          <= last_data;   // lines up with last rd_data_valid
        end
    end

    always_ff @(posedge ui_clk) begin
        if (app_rd_data_valid) begin
            rd_data <= app_rd_data;
        end
    end

    always_comb begin
        app.en   = (state == ISSUE);
        app.cmd  = CMD_READ;
        app.addr = issue_addr;
    end

    // controller only returns data for commands this channel sent
    a_no_data_in_idle : assert property (
        @(posedge ui_clk) disable iff (!arst_n)
        app_rd_data_valid |-> state != IDLE
    ) else $error("read data returned with no burst open");

endmodule

// File: rtl/dma_wr_engine.sv
`timescale 1ns/100ps

module dma_wr_engine #(
    parameter int DATA_W = 256
) (
    input  logic                ui_clk,
    input  logic                arst_n,
    input  logic                start,        // grant pulse from arbiter
    input  dma_pkg::burst_cmd_t cmd,
    input  logic [DATA_W-1:0]   src_data,     // head word of fwft source
    input  logic                app_rdy,
    input  logic                app_wdf_rdy,
    output dma_pkg::app_req_t   app,
    output logic [DATA_W-1:0]   wdf_data,
    output logic                wdf_wren,
    output logic                wdf_end,
    output logic                src_pop,
    output logic                done
);
    import dma_pkg::*;

    typedef enum logic {
        IDLE,
        BURST
    } state_e;

    state_e            state;
    logic [ADDR_W-1:0] addr_q;      // address of the beat on the port
    logic [LEN_W-1:0]  beats_left;
    logic              beat_xfer;
    logic              last_beat;

    // command and data leave together, so both readies are needed
    assign beat_xfer = (state == BURST) && app_rdy && app_wdf_rdy;
    assign last_beat = (beats_left == LEN_W'(1));

    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            beats_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= BURST;
                        beats_left <= cmd.len;
                    end
                end
                BURST: begin
                    if (beat_xfer) begin
                        beats_left <= beats_left - 1'b1;
                        if (last_beat) begin
                            state <= IDLE;
                            done  <= 1'b1;   // one cycle after last beat
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // beat address walks up per transfer
    always_ff @(posedge ui_clk) begin
        if (state == IDLE && start) begin
            addr_q <= cmd.addr;
        end else if (beat_xfer) begin
            addr_q <= addr_q + ADDR_STEP;
        end
    end

    always_comb begin
        app.en   = (state == BURST);
        app.cmd  = CMD_WRITE;
        app.addr = addr_q;
    end

    assign wdf_data = src_data;       // source holds its head until popped
    assign wdf_wren = (state == BURST);
    assign wdf_end  = wdf_wren;       // single word per beat
    assign src_pop  = beat_xfer;

    // the arbiter must not grant again while this channel owns the port
    a_start_in_idle : assert property (
        @(posedge ui_clk) disable iff (!arst_n)
        start |-> state == IDLE
    ) else $error("write start while burst active");

endmodule

// File: testbench/app_mem_model.sv
`timescale 1ns/100ps

module app_mem_model #(
    parameter int DATA_W = 256,
    parameter int SEED   = 1
) (
    input  logic              ui_clk,
    input  logic              arst_n,
    input  dma_pkg::app_req_t app,
    input  logic [DATA_W-1:0] app_wdf_data,
    input  logic              app_wdf_wren,
    output logic              app_rdy,
    output logic              app_wdf_rdy,
    output logic [DATA_W-1:0] app_rd_data,
    output logic              app_rd_data_valid
);
    import dma_pkg::*;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0] rd_addr_q [$];   // reads waiting for their data
    int                rd_due_q [$];
    int                seed;
    int                cycle = 0;

    // never-written cells show their own address in every 32-bit lane
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] w;
        for (int i = 0; i < DATA_W / 32; i++) begin
            w[i*32 +: 32] = {4'hd, addr} ^ i;
        end
        return w;
    endfunction

    always @(posedge ui_clk) begin
        cycle = cycle + 1;
        if (arst_n && app.en && app_rdy) begin
            if (app.cmd == CMD_WRITE && app_wdf_rdy && app_wdf_wren) begin
                mem[app.addr] = app_wdf_data;
            end else if (app.cmd == CMD_READ) begin
                rd_addr_q.push_back(app.addr);
                rd_due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 6));
            end
        end
    end

    initial begin
        seed              = SEED;
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
        forever begin
            @(negedge ui_clk);
            app_rdy           = arst_n && (($random(seed) & 3) != 0);
            app_wdf_rdy       = arst_n && (($random(seed) & 3) != 0);
            app_rd_data_valid = 1'b0;
            // in order and at most one beat per cycle
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle + 1) begin
                app_rd_data_valid = 1'b1;
                app_rd_data = mem.exists(rd_addr_q[0]) ? mem[rd_addr_q[0]]
                                                       : fill_word(rd_addr_q[0]);
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
            end
        end
    end

endmodule

// File: testbench/tb_dma_app.sv
`timescale 1ns/100ps

module tb_dma_app;
    import dma_pkg::*;

    localparam int DATA_W  = 64;
    localparam int SEED    = 32'h8450;
    localparam int MAX_LEN = 16;
    localparam int N_SOLO  = 12;      // write-only bursts first
    localparam int N_RR    = 8;       // then read/write pairs
    localparam int N_WR    = N_SOLO + N_RR;
    localparam int LIMIT   = (N_WR + N_RR) * (MAX_LEN + 20) * 4;
    localparam logic [ADDR_W-1:0] REGION_B = 28'h0100000;

    logic              ui_clk = 1'b0;
    logic              arst_n;
    logic              wr_req, rd_req, wr_data_pop, wr_done, rd_done, rd_data_valid;
    logic              app_wdf_wren, app_wdf_end, app_rdy, app_wdf_rdy, app_rd_data_valid;
    logic [DATA_W-1:0] wr_data, rd_data, app_wdf_data, app_rd_data, prev_wdata;
    burst_cmd_t        wr_cmd, rd_cmd;
    app_req_t          app, prev_app;

    int                seed = SEED;
    burst_cmd_t        wr_list [N_WR];
    burst_cmd_t        rd_list [N_RR];
    logic [DATA_W-1:0] src_q [$];            // write source with its head on wr_data
    logic [DATA_W-1:0] model_mem [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0] exp_wr_addr [$];
    logic [ADDR_W-1:0] exp_rd_addr [$];
    logic [DATA_W-1:0] exp_rd_data [$];
    logic              rr_phase = 1'b0, prev_en = 1'b0, prev_stall = 1'b0, prev_wr_xfer = 1'b0;
    app_cmd_e          rr_next = CMD_READ;
    app_cmd_e          burst_cmd = CMD_WRITE;
    int                wr_done_cnt = 0, rd_done_cnt = 0;

    always #50 ui_clk = ~ui_clk;

    dma_app_top #(.DATA_W(DATA_W)) i_dut (.*);

    app_mem_model #(.DATA_W(DATA_W), .SEED(SEED)) i_mem (.*);

    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_app_req(input string name, input app_req_t exp, input app_req_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected en=%b cmd=%0d addr=%h, actual en=%b cmd=%0d addr=%h",
                     name, exp.en, exp.cmd, exp.addr, act.en, act.cmd, act.addr);
            abort_run("app request mismatch");
        end
    endtask

    task automatic compare_data(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run("data word mismatch");
        end
    endtask

    task automatic compare_cmd(input string name, input app_cmd_e exp, input app_cmd_e act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            abort_run("app command mismatch");
        end
    endtask

    task automatic build_bursts();
        burst_cmd_t c;
        for (int i = 0; i < N_WR; i++) begin
            c.len  = LEN_W'(1 + $unsigned($random(seed)) % MAX_LEN);
            c.addr = ADDR_W'($unsigned($random(seed)) % 64) * ADDR_STEP;
            if (i >= N_SOLO) begin
                c.addr = c.addr + REGION_B;   // keep clear of the read-back area
            end
            wr_list[i] = c;
            for (int k = 0; k < c.len; k++) begin
                src_q.push_back({$random(seed), $random(seed)});
            end
        end
        // reads cover part of a write-only burst
        for (int i = 0; i < N_RR; i++) begin
            c       = wr_list[$unsigned($random(seed)) % N_SOLO];
            c.len   = LEN_W'(1 + $unsigned($random(seed)) % c.len);
            rd_list[i] = c;
        end
    endtask

    task automatic run_write(input burst_cmd_t c);
        for (int k = 0; k < c.len; k++) begin
            exp_wr_addr.push_back(c.addr + ADDR_W'(k) * ADDR_STEP);
        end
        wr_cmd = c;
        wr_req = 1'b1;
        do @(posedge ui_clk); while (!wr_done);
        @(negedge ui_clk);
    endtask

    task automatic run_read(input burst_cmd_t c);
        logic [ADDR_W-1:0] a;
        for (int k = 0; k < c.len; k++) begin
            a = c.addr + ADDR_W'(k) * ADDR_STEP;
            exp_rd_addr.push_back(a);
            exp_rd_data.push_back(model_mem[a]);
        end
        rd_cmd = c;
        rd_req = 1'b1;
        do @(posedge ui_clk); while (!rd_done);
        @(negedge ui_clk);
    endtask

    initial begin
        wr_data = '0;
        forever begin
            @(negedge ui_clk);
            wr_data = (src_q.size() != 0) ? src_q[0] : '0;
        end
    end

    always @(posedge ui_clk) begin
        app_req_t exp_req;
        logic     wr_xfer;
        logic     rd_xfer;
        if (arst_n) begin
            wr_xfer = app.en && app_rdy && app_wdf_rdy && app.cmd == CMD_WRITE;
            rd_xfer = app.en && app_rdy && app.cmd == CMD_READ;
            if (wr_data_pop !== wr_xfer) abort_run("write source pop without a beat transfer");
            if (app_wdf_end !== app_wdf_wren) abort_run("app_wdf_end differs from app_wdf_wren");
            if (app_wdf_wren !== (app.en && app.cmd == CMD_WRITE)) begin
                abort_run("app_wdf_wren out of step with the write command");
            end
            if (prev_stall) begin
                compare_app_req("hold app", prev_app, app);
                if (prev_app.cmd == CMD_WRITE) begin
                    compare_data("hold wdf data", prev_wdata, app_wdf_data);
                end
            end
            if (app.en && !prev_en) begin
                if (rr_phase) begin
                    compare_cmd("round robin", rr_next, app.cmd);
                    rr_next = (rr_next == CMD_READ) ? CMD_WRITE : CMD_READ;
                end else begin
                    compare_cmd("write only phase", CMD_WRITE, app.cmd);
                end
                burst_cmd = app.cmd;
            end else if (app.en) begin
                compare_cmd("burst cmd", burst_cmd, app.cmd);   // no interleave
            end
            if (wr_xfer) begin
                if (exp_wr_addr.size() == 0) abort_run("write beat beyond the burst length");
                exp_req = '{en: 1'b1, cmd: CMD_WRITE, addr: exp_wr_addr[0]};
                compare_app_req("write beat", exp_req, app);
                compare_data("write data", src_q[0], app_wdf_data);
                model_mem[exp_wr_addr[0]] = src_q[0];
                void'(exp_wr_addr.pop_front());
                void'(src_q.pop_front());
            end
            if (rd_xfer) begin
                if (exp_rd_addr.size() == 0) abort_run("read command beyond the burst length");
                exp_req = '{en: 1'b1, cmd: CMD_READ, addr: exp_rd_addr[0]};
                compare_app_req("read cmd", exp_req, app);
                void'(exp_rd_addr.pop_front());
            end
            if (rd_data_valid) begin
                if (exp_rd_data.size() == 0) abort_run("read data beyond the burst length");
                compare_data("read data", exp_rd_data[0], rd_data);
                void'(exp_rd_data.pop_front());
            end
            if (wr_done) begin
                if (!prev_wr_xfer || exp_wr_addr.size() != 0) begin
                    abort_run("write done not right after last beat");
                end
                wr_done_cnt++;
            end
            if (rd_done) begin
                if (!rd_data_valid || exp_rd_data.size() != 0 || exp_rd_addr.size() != 0) begin
                    abort_run("read done without the last data beat");
                end
                rd_done_cnt++;
            end
            prev_en      = app.en;
            prev_stall   = app.en && !wr_xfer && !rd_xfer;
            prev_app     = app;
            prev_wdata   = app_wdf_data;
            prev_wr_xfer = wr_xfer;
        end
    end

    initial begin
        arst_n = 1'b0;
        wr_req = 1'b0;
        rd_req = 1'b0;
        wr_cmd = '0;
        rd_cmd = '0;
        build_bursts();
        repeat (3) @(negedge ui_clk);
        arst_n = 1'b1;
        repeat (4) begin
            @(posedge ui_clk);
            if ({app.en, app_wdf_wren, wr_data_pop, rd_data_valid, wr_done, rd_done} !== '0) begin
                abort_run("DUT output active after reset with no request");
            end
        end
        @(negedge ui_clk);
        for (int i = 0; i < N_SOLO; i++) run_write(wr_list[i]);
        wr_req = 1'b0;
        rr_phase = 1'b1;   // last owner was write, so read leads
        fork
            begin
                for (int i = N_SOLO; i < N_WR; i++) run_write(wr_list[i]);
                wr_req = 1'b0;
            end
            begin
                for (int i = 0; i < N_RR; i++) run_read(rd_list[i]);
                rd_req = 1'b0;
            end
        join
        repeat (4) @(negedge ui_clk);
        if (wr_done_cnt == N_WR && rd_done_cnt == N_RR && src_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("done pulse count or write source level wrong at the end of the run");
            $display("Test failed");
            $fatal(1, "burst count mismatch");
        end
    end

    initial begin
        repeat (LIMIT) @(posedge ui_clk);
        $display("Test failed");
        $fatal(1, "watchdog expired after %0d cycles before all bursts finished", LIMIT);
    end

endmodule
